/* Makefile */
TOP = tb_datamem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -f vlog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module datamem

clean:
	rm -rf obj_dir

/* design/board_io_regs.sv */
module board_io_regs import datamem_pkg::*; (
	input logic clk,
	input logic nrst,

	// Word index inside the I/O window
	input io_sel_t sel,
	// Mask already gated to the I/O region by the top
	input byte_en_t we,
	input word_t wdata,
	// Selected I/O word, unregistered
	output word_t rdata,

	// Board pins
	input logic [BTN_W-1:0] btn,
	input logic [SW_W-1:0] sw,
	output logic [LED_W-1:0] led
);

	// Sampled inputs, zero-extended to a full word
	word_t btn_word;
	word_t sw_word;

	// LED word, whole word is readable
	word_t led_word;

	// Button and switch sampling, once per clock
	// Core writes to these two words never land here
	always_ff @(posedge clk) begin
		if (!nrst) begin
			btn_word <= '0;
			sw_word <= '0;
		end else begin
			btn_word <= word_t'(btn);
			sw_word <= word_t'(sw);
		end
	end

	// LED word update
	// Byte lanes follow the mask, any pattern allowed
	always_ff @(posedge clk) begin
		if (!nrst) begin
			led_word <= '0;
		end else if (sel == io_sel_t'(IO_LED_ADDR)) begin
			for (int i = 0; i < BE_W; i++) begin
				if (we[i]) begin
					led_word[i*BYTE_W +: BYTE_W] <= wdata[i*BYTE_W +: BYTE_W];
				end
			end
		end
	end

	// Only the low bits drive the board
	assign led = led_word[LED_W-1:0];

	// Read select
	// Top registers this alongside the RAM read word
	always_comb begin
		case (sel)
			io_sel_t'(IO_BTN_ADDR): rdata = btn_word;
			io_sel_t'(IO_SW_ADDR): rdata = sw_word;
			io_sel_t'(IO_LED_ADDR): rdata = led_word;
			// Fourth slot is not mapped
			default: rdata = '0;
		endcase
	end

endmodule

/* design/con_wb_slave.sv */
module con_wb_slave import datamem_pkg::*; (
	input logic clk,
	input logic nrst,

	// Wishbone classic slave side
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input ram_addr_t wb_adr,
	input byte_en_t wb_sel,
	input word_t wb_dat_i,
	output logic wb_ack,
	output word_t wb_dat_o,

	// RAM port B
	output ram_addr_t ram_addr,
	output byte_en_t ram_we,
	output word_t ram_wdata,
	input word_t ram_rdata
);

	wb_state_t state;
	wb_state_t next_state;

	// New request seen while idle
	logic req;

	assign req = wb_cyc && wb_stb;

	// Master holds address and data stable until ack
	// so the RAM can follow the bus directly
	assign ram_addr = wb_adr;
	assign ram_wdata = wb_dat_i;

	// State register
	always_ff @(posedge clk) begin
		if (!nrst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	// Next state and RAM enables
	always_comb begin
		next_state = state;
		ram_we = '0;
		case (state)
			IDLE: begin
				if (req) begin
					// Write commits on the edge that first sees the request
					if (wb_we) begin
						ram_we = wb_sel;
					end
					next_state = ACK;
				end
			end
			ACK: begin
				// Enables stay low here, no second write
				// stb still high afterwards starts a new access
				next_state = IDLE;
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	// One-cycle acknowledge, one clock after the request edge
	assign wb_ack = (state == ACK);

	// RAM read word captured on the request edge
	// Only meaningful while ack is high
	assign wb_dat_o = wb_ack ? ram_rdata : '0;

endmodule

/* design/datamem.sv */
module datamem import datamem_pkg::*; (
	input logic clk,
	input logic nrst,

	// Core data port
	input core_addr_t core_addr,
	input byte_en_t core_we,
	input word_t core_wdata,
	output word_t core_rdata,

	// Protocol controller, Wishbone classic
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input ram_addr_t wb_adr,
	input byte_en_t wb_sel,
	input word_t wb_dat_i,
	output logic wb_ack,
	output word_t wb_dat_o,

	// Board I/O
	input logic [BTN_W-1:0] btn,
	input logic [SW_W-1:0] sw,
	output logic [LED_W-1:0] led
);

	// Region decode for the current core address
	logic ram_hit;
	logic io_hit;

	// Region of the access issued last cycle
	logic ram_hit_q;
	logic io_hit_q;

	// Gated write masks
	byte_en_t ram_a_we;
	byte_en_t io_we;

	word_t ram_a_rdata;
	word_t io_rdata;
	// I/O word held to line up with the RAM latency
	word_t io_rdata_q;

	// Port B wiring
	ram_addr_t ram_b_addr;
	byte_en_t ram_b_we;
	word_t ram_b_wdata;
	word_t ram_b_rdata;

	// 0x000 to 0x3FF is RAM, 0x400 to 0x402 is board I/O
	// Everything else is unmapped
	assign ram_hit = core_addr < core_addr_t'(RAM_DEPTH);
	assign io_hit = (core_addr >= IO_BTN_ADDR) && (core_addr <= IO_LED_ADDR);

	// Only the selected region sees the write
	assign ram_a_we = ram_hit ? core_we : '0;
	assign io_we = io_hit ? core_we : '0;

	// Region choice follows the one-cycle RAM read
	always_ff @(posedge clk) begin
		if (!nrst) begin
			ram_hit_q <= 1'b0;
			io_hit_q <= 1'b0;
		end else begin
			ram_hit_q <= ram_hit;
			io_hit_q <= io_hit;
		end
	end

	always_ff @(posedge clk) begin
		io_rdata_q <= io_rdata;
	end

	// Read mux, unmapped reads return zero
	always_comb begin
		if (ram_hit_q) begin
			core_rdata = ram_a_rdata;
		end else if (io_hit_q) begin
			core_rdata = io_rdata_q;
		end else begin
			core_rdata = '0;
		end
	end

	dual_port_ram u_ram (
		.clk     (clk),
		.a_addr  (core_addr[RAM_AW-1:0]),
		.a_we    (ram_a_we),
		.a_wdata (core_wdata),
		.a_rdata (ram_a_rdata),
		.b_addr  (ram_b_addr),
		.b_we    (ram_b_we),
		.b_wdata (ram_b_wdata),
		.b_rdata (ram_b_rdata)
	);

	// Window is aligned, low bits index the I/O word
	board_io_regs u_io (
		.clk   (clk),
		.nrst  (nrst),
		.sel   (core_addr[IO_SEL_W-1:0]),
		.we    (io_we),
		.wdata (core_wdata),
		.rdata (io_rdata),
		.btn   (btn),
		.sw    (sw),
		.led   (led)
	);

	// Controller port reaches the RAM only
	con_wb_slave u_wb (
		.clk       (clk),
		.nrst      (nrst),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_sel    (wb_sel),
		.wb_dat_i  (wb_dat_i),
		.wb_ack    (wb_ack),
		.wb_dat_o  (wb_dat_o),
		.ram_addr  (ram_b_addr),
		.ram_we    (ram_b_we),
		.ram_wdata (ram_b_wdata),
		.ram_rdata (ram_b_rdata)
	);

endmodule

/* design/datamem_pkg.sv */
package datamem_pkg;

	// Data path widths
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;
	// One enable bit per byte lane
	localparam int BE_W = WORD_W / BYTE_W;

	// Core side sees an 11-bit word address
	localparam int CORE_AW = 11;

	// Shared RAM size in words
	localparam int RAM_DEPTH = 1024;
	localparam int RAM_AW = $clog2(RAM_DEPTH);

	// Word index inside the board I/O window
	localparam int IO_SEL_W = 2;

	// One data word
	typedef logic [WORD_W-1:0] word_t;

	// Byte-enable mask, bit n writes byte n, all zeros is no write
	typedef logic [BE_W-1:0] byte_en_t;

	// Word address as issued by the core
	typedef logic [CORE_AW-1:0] core_addr_t;

	// Word address into the RAM, also used as the Wishbone address
	typedef logic [RAM_AW-1:0] ram_addr_t;

	// Low address bits that pick a board I/O word
	typedef logic [IO_SEL_W-1:0] io_sel_t;

	// Board I/O words, right above the RAM
	localparam core_addr_t IO_BTN_ADDR = 11'h400;
	localparam core_addr_t IO_SW_ADDR = 11'h401;
	localparam core_addr_t IO_LED_ADDR = 11'h402;

	// Board pin counts
	localparam int BTN_W = 4;
	localparam int SW_W = 3;
	localparam int LED_W = 4;

	// Wishbone slave FSM
	// IDLE waits for cyc and stb, ACK returns the acknowledge
	typedef enum logic {
		IDLE,
		ACK
	} wb_state_t;

endpackage

/* design/dual_port_ram.sv */
module dual_port_ram import datamem_pkg::*; (
	input logic clk,

	// Port A, owned by the core
	input ram_addr_t a_addr,
	input byte_en_t a_we,
	input word_t a_wdata,
	output word_t a_rdata,

	// Port B, owned by the protocol controller
	input ram_addr_t b_addr,
	input byte_en_t b_we,
	input word_t b_wdata,
	output word_t b_rdata
);

	// Storage array
	// No reset and no init, contents come up undefined
	word_t mem [RAM_DEPTH];

	// Port A
	// Read word registered on the same edge as the write
	// Nonblocking read returns the word as it was before the write
	always @(posedge clk) begin
		a_rdata <= mem[a_addr];
		// Only the enabled lanes change
		for (int i = 0; i < BE_W; i++) begin
			if (a_we[i]) begin
				mem[a_addr][i*BYTE_W +: BYTE_W] <= a_wdata[i*BYTE_W +: BYTE_W];
			end
		end
	end

	// Port B
	// Same behaviour as port A, on its own address
	always @(posedge clk) begin
		b_rdata <= mem[b_addr];
		for (int i = 0; i < BE_W; i++) begin
			if (b_we[i]) begin
				mem[b_addr][i*BYTE_W +: BYTE_W] <= b_wdata[i*BYTE_W +: BYTE_W];
			end
		end
	end

	// Same word written from both ports in one cycle
	// leaves the lane contents undefined

endmodule

/* tests/tb_datamem.sv */
module tb_datamem import datamem_pkg::*; ();

	// Row port codes
	localparam logic PORT_CORE = 1'b0;
	localparam logic PORT_WB = 1'b1;
	localparam int MAX_ROWS = 64;
	// Give up on a missing acknowledge after this many clocks
	localparam int ACK_WAIT_MAX = 8;

	logic clk;
	logic nrst;
	core_addr_t core_addr;
	byte_en_t core_we;
	word_t core_wdata;
	word_t core_rdata;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	ram_addr_t wb_adr;
	byte_en_t wb_sel;
	word_t wb_dat_i;
	logic wb_ack;
	word_t wb_dat_o;
	logic [BTN_W-1:0] btn;
	logic [SW_W-1:0] sw;
	logic [LED_W-1:0] led;

	// Operation table with expected columns filled by the model
	logic row_port [MAX_ROWS];
	byte_en_t row_mask [MAX_ROWS];
	core_addr_t row_addr [MAX_ROWS];
	word_t row_data [MAX_ROWS];
	logic [BTN_W-1:0] row_btn [MAX_ROWS];
	logic [SW_W-1:0] row_sw [MAX_ROWS];
	logic row_rd [MAX_ROWS];
	word_t row_exp [MAX_ROWS];
	logic [LED_W-1:0] row_led [MAX_ROWS];
	int n_rows;

	// Reference model state
	word_t shadow_ram [RAM_DEPTH];
	word_t led_word;

	int seed;
	int errors;
	int checks;
	int cycles = 0;

	datamem u_dut (
		.clk        (clk),
		.nrst       (nrst),
		.core_addr  (core_addr),
		.core_we    (core_we),
		.core_wdata (core_wdata),
		.core_rdata (core_rdata),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_sel     (wb_sel),
		.wb_dat_i   (wb_dat_i),
		.wb_ack     (wb_ack),
		.wb_dat_o   (wb_dat_o),
		.btn        (btn),
		.sw         (sw),
		.led        (led)
	);

	always #50 clk = ~clk;

	// Run limit from the table length
	always @(posedge clk) begin
		cycles++;
		if (n_rows > 0 && cycles > n_rows * 4 + 50) begin
			$display("Timeout: run still going after %0d clock cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	// Byte-enable rule where bit n replaces byte n
	function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_en_t mask);
		word_t result;
		result = old_word;
		for (int i = 0; i < BE_W; i++) begin
			if (mask[i]) begin
				result[i*BYTE_W +: BYTE_W] = new_word[i*BYTE_W +: BYTE_W];
			end
		end
		return result;
	endfunction

	// Word the core should see for an address
	function automatic word_t core_read_value(core_addr_t a, logic [BTN_W-1:0] b,
			logic [SW_W-1:0] s);
		if (a < 11'h400) begin
			return shadow_ram[a[RAM_AW-1:0]];
		end
		if (a == 11'h400) begin
			return word_t'(b);
		end
		if (a == 11'h401) begin
			return word_t'(s);
		end
		if (a == 11'h402) begin
			return led_word;
		end
		// Unmapped
		return '0;
	endfunction

	// Append a row and advance the model
	// Zero mask means a read
	task automatic add_row(input logic port, input byte_en_t mask, input core_addr_t addr,
			input logic [BTN_W-1:0] b, input logic [SW_W-1:0] s);
		word_t data;
		data = $random(seed);
		row_port[n_rows] = port;
		row_mask[n_rows] = mask;
		row_addr[n_rows] = addr;
		row_data[n_rows] = data;
		row_btn[n_rows] = b;
		row_sw[n_rows] = s;
		row_rd[n_rows] = (mask == '0);
		row_exp[n_rows] = '0;
		if (mask == '0) begin
			if (port == PORT_WB) begin
				row_exp[n_rows] = shadow_ram[addr[RAM_AW-1:0]];
			end else begin
				row_exp[n_rows] = core_read_value(addr, b, s);
			end
		end else if (port == PORT_WB || addr < 11'h400) begin
			shadow_ram[addr[RAM_AW-1:0]] = merge_bytes(shadow_ram[addr[RAM_AW-1:0]], data, mask);
		end else if (addr == 11'h402) begin
			led_word = merge_bytes(led_word, data, mask);
		end
		row_led[n_rows] = led_word[LED_W-1:0];
		n_rows++;
	endtask

	task automatic build_table();
		// Reset values of the I/O window
		add_row(PORT_CORE, 4'h0, 11'h400, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h401, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h402, 4'h0, 3'h0);
		// Core stores and loads
		// Full word first so no byte stays unknown
		add_row(PORT_CORE, 4'hF, 11'h010, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h010, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h3, 11'h010, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h010, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'hC, 11'h010, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h010, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'hF, 11'h3FF, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h9, 11'h3FF, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h3FF, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'hF, 11'h003, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h003, 4'h0, 3'h0);
		// Shared RAM where each side reads what the other wrote
		add_row(PORT_WB, 4'hF, 11'h020, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h020, 4'h0, 3'h0);
		add_row(PORT_WB, 4'h2, 11'h020, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h0, 11'h020, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'hF, 11'h021, 4'h0, 3'h0);
		add_row(PORT_WB, 4'h0, 11'h021, 4'h0, 3'h0);
		add_row(PORT_CORE, 4'h8, 11'h021, 4'h0, 3'h0);
		add_row(PORT_WB, 4'h0, 11'h021, 4'h0, 3'h0);
		add_row(PORT_WB, 4'h0, 11'h010, 4'h0, 3'h0);
		add_row(PORT_WB, 4'hF, 11'h155, 4'h0, 3'h0);
		add_row(PORT_WB, 4'h0, 11'h155, 4'h0, 3'h0);
		// Buttons and switches
		// Stores there are dropped
		add_row(PORT_CORE, 4'h0, 11'h400, 4'hA, 3'h5);
		add_row(PORT_CORE, 4'h0, 11'h401, 4'hA, 3'h5);
		add_row(PORT_CORE, 4'hF, 11'h400, 4'hA, 3'h5);
		add_row(PORT_CORE, 4'h0, 11'h400, 4'hA, 3'h5);
		add_row(PORT_CORE, 4'hF, 11'h401, 4'hA, 3'h5);
		add_row(PORT_CORE, 4'h0, 11'h401, 4'hA, 3'h5);
		add_row(PORT_CORE, 4'h0, 11'h400, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h401, 4'h3, 3'h6);
		// LED word with byte lanes per mask
		add_row(PORT_CORE, 4'hF, 11'h402, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h402, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h1, 11'h402, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h402, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h6, 11'h402, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h402, 4'h3, 3'h6);
		// Unmapped space
		// Aliases of RAM and LED words must not move
		add_row(PORT_CORE, 4'h0, 11'h403, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h7FF, 4'h3, 3'h6);
		// Low bits match the LED word index
		add_row(PORT_CORE, 4'h0, 11'h7FE, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'hF, 11'h403, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'hF, 11'h7FF, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'hF, 11'h7FE, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h003, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h3FF, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h402, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h403, 4'h3, 3'h6);
		add_row(PORT_CORE, 4'h0, 11'h7FF, 4'h3, 3'h6);
	endtask

	// Next edge plus drive offset
	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	// Core access with read data one clock after the address
	task automatic core_access(input int r);
		core_addr = row_addr[r];
		core_we = row_rd[r] ? '0 : row_mask[r];
		core_wdata = row_data[r];
		tick();
		core_we = '0;
		if (row_rd[r]) begin
			checks++;
			assert (core_rdata === row_exp[r]) else begin
				$display("FAIL %0t: core read of %h returned %h, expected %h", $time,
					row_addr[r], core_rdata, row_exp[r]);
				errors++;
			end
		end
	endtask

	// Single-access Wishbone classic cycle
	task automatic wb_access(input int r);
		int waited;
		wb_adr = row_addr[r][RAM_AW-1:0];
		wb_we = !row_rd[r];
		wb_sel = row_mask[r];
		wb_dat_i = row_data[r];
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		// No edge has seen the request yet
		checks++;
		assert (wb_ack === 1'b0) else begin
			$display("FAIL %0t: wb_ack high before the request edge", $time);
			errors++;
		end
		waited = 0;
		do begin
			tick();
			waited++;
		end while (wb_ack !== 1'b1 && waited < ACK_WAIT_MAX);
		checks++;
		assert (wb_ack === 1'b1) else begin
			$display("Wishbone slave never acknowledged the access to %h", wb_adr);
			errors++;
		end
		checks++;
		assert (waited == 1) else begin
			$display("FAIL %0t: wb_ack after %0d clocks, expected 1", $time, waited);
			errors++;
		end
		if (row_rd[r]) begin
			checks++;
			assert (wb_dat_o === row_exp[r]) else begin
				$display("FAIL %0t: wb read of %h returned %h, expected %h", $time,
					wb_adr, wb_dat_o, row_exp[r]);
				errors++;
			end
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_sel = '0;
		tick();
		// One-cycle acknowledge
		checks++;
		assert (wb_ack === 1'b0) else begin
			$display("FAIL %0t: wb_ack held for more than one cycle", $time);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		nrst = 1'b0;
		core_addr = '0;
		core_we = '0;
		core_wdata = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_sel = '0;
		wb_dat_i = '0;
		btn = '0;
		sw = '0;
		seed = 27;
		errors = 0;
		checks = 0;
		n_rows = 0;
		led_word = '0;
		build_table();
		repeat (5) @(posedge clk);
		#10;
		nrst = 1'b1;
		// State straight out of reset
		checks++;
		assert (wb_ack === 1'b0 && led === '0) else begin
			$display("FAIL %0t: after reset wb_ack %b led %h, expected 0 and 0", $time,
				wb_ack, led);
			errors++;
		end
		for (int r = 0; r < n_rows; r++) begin
			// Inputs settle one edge ahead of the access
			btn = row_btn[r];
			sw = row_sw[r];
			tick();
			if (row_port[r] == PORT_CORE) begin
				core_access(r);
			end else begin
				wb_access(r);
			end
			checks++;
			assert (led === row_led[r]) else begin
				$display("FAIL %0t: led %h, expected %h after row %0d", $time, led,
					row_led[r], r);
				errors++;
			end
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
design/datamem_pkg.sv
design/dual_port_ram.sv
design/board_io_regs.sv
design/con_wb_slave.sv
design/datamem.sv
tests/tb_datamem.sv
